//--- logic/video_cfg.svh
`ifndef VIDEO_CFG_SVH
`define VIDEO_CFG_SVH

// output raster, clocks per line and lines per frame
`define H_TOTAL            24
`define H_VISIBLE          16
`define H_SYNC_START       18
`define H_SYNC_WIDTH       3
`define V_TOTAL            12
`define V_TOTAL_INTERLACED 13  // add-line mode
`define V_VISIBLE          10
`define V_SYNC_START       10
`define V_SYNC_WIDTH       2

// border around the buffered picture, in output pixels and lines
`define H_OFFSET           2
`define V_OFFSET           2
`define PIXEL_FACTOR       2

`define HSYNC_ACTIVE       1'b0
`define VSYNC_ACTIVE       1'b0

// line buffer geometry
`define BUF_LINE_LEN       6
`define BUF_LINES          4
`define RAM_ADDR_BITS      5

`define QUEUE_DEPTH        4  // also the initial credit count

`endif

//--- logic/video_pkg.sv
package video_pkg;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    // one source pixel as it arrives on the input
    typedef struct packed {
        rgb_t pixel;
        logic start_of_frame;  // first pixel of a source frame
    } pixel_beat_t;

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic field;
        logic draw_area;
    } sync_out_t;

endpackage

//--- logic/pixel_queue.sv
`timescale 1ns/1ps
`include "video_cfg.svh"

module pixel_queue (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   in_valid,
    input  video_pkg::pixel_beat_t in_beat,
    input  logic                   pop,
    output video_pkg::pixel_beat_t out_beat,
    output logic                   not_empty,
    output logic                   credit_return
);
    import video_pkg::*;

    localparam int PTR_BITS = $clog2(`QUEUE_DEPTH);
    localparam int CNT_BITS = $clog2(`QUEUE_DEPTH + 1);

    pixel_beat_t         entries [`QUEUE_DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                take;

    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        return (ptr == PTR_BITS'(`QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign take      = pop && not_empty;
    assign not_empty = (count != '0);
    assign out_beat  = entries[rd_ptr];  // oldest entry

    always_ff @(posedge clock) begin
        if (in_valid) begin
            entries[wr_ptr] <= in_beat;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (in_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (take) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            credit_return <= take;  // one credit back per released entry
            case ({in_valid, take})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- logic/pixel_capture.sv
`timescale 1ns/1ps
`include "video_cfg.svh"

module pixel_capture (
    input  logic                      clock,
    input  logic                      reset,
    input  video_pkg::pixel_beat_t    beat,
    input  logic                      not_empty,
    output logic                      pop,
    output logic                      wr_en,
    output logic [`RAM_ADDR_BITS-1:0] wr_addr,
    output video_pkg::rgb_t           wr_data,
    output logic                      start_trigger
);

    localparam int AW        = `RAM_ADDR_BITS;
    localparam int PACE_BITS = $clog2(`PIXEL_FACTOR + 1);
    localparam int COL_BITS  = $clog2(`BUF_LINE_LEN + 1);
    localparam int LINE_BITS = $clog2(`BUF_LINES + 1);

    logic [PACE_BITS-1:0] pace;
    logic [COL_BITS-1:0]  col;
    logic [COL_BITS-1:0]  col_sel;
    logic [LINE_BITS-1:0] line;
    logic [LINE_BITS-1:0] line_sel;

    // source pixel rate is one per PIXEL_FACTOR clocks
    assign pop = not_empty && (pace == '0);

    // a start_of_frame beat lands in the top left corner
    assign col_sel  = beat.start_of_frame ? '0 : col;
    assign line_sel = beat.start_of_frame ? '0 : line;

    always_ff @(posedge clock) begin
        if (!reset) begin
            pace <= '0;
        end else if (pop) begin
            pace <= PACE_BITS'(`PIXEL_FACTOR - 1);
        end else if (pace != '0) begin
            pace <= pace - 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            col  <= '0;
            line <= '0;
        end else if (pop) begin
            if (col_sel == COL_BITS'(`BUF_LINE_LEN - 1)) begin
                col  <= '0;
                line <= (line_sel == LINE_BITS'(`BUF_LINES - 1)) ? '0 : line_sel + 1'b1;
            end else begin
                col  <= col_sel + 1'b1;
                line <= line_sel;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            wr_en         <= 1'b0;
            start_trigger <= 1'b0;
        end else begin
            wr_en         <= pop;
            start_trigger <= pop && beat.start_of_frame;
        end
    end

    always_ff @(posedge clock) begin
        if (pop) begin
            wr_addr <= AW'(line_sel * `BUF_LINE_LEN + col_sel);  // line ring in the RAM
            wr_data <= beat.pixel;
        end
    end

endmodule

//--- logic/line_ram.sv
`timescale 1ns/1ps
`include "video_cfg.svh"

module line_ram (
    input  logic                      clock,
    input  logic                      wr_en,
    input  logic [`RAM_ADDR_BITS-1:0] wr_addr,
    input  video_pkg::rgb_t           wr_data,
    input  logic [`RAM_ADDR_BITS-1:0] rd_addr,
    output video_pkg::rgb_t           rd_data
);
    import video_pkg::*;

    localparam int DEPTH = `BUF_LINE_LEN * `BUF_LINES;

    rgb_t                      mem [DEPTH];
    logic [`RAM_ADDR_BITS-1:0] rd_addr_q;

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // address register then data register, two clocks address to data
    always_ff @(posedge clock) begin
        rd_addr_q <= rd_addr;
        rd_data   <= mem[rd_addr_q];
    end

endmodule

//--- logic/video_timing.sv
`timescale 1ns/1ps
`include "video_cfg.svh"

module video_timing (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      start_trigger,
    input  logic                      line_doubler,
    input  logic                      add_line,
    output logic [`RAM_ADDR_BITS-1:0] rd_addr,
    input  video_pkg::rgb_t           rd_data,
    output video_pkg::rgb_t           rgb,
    output video_pkg::sync_out_t      sync
);

    localparam int X_BITS    = $clog2(`H_TOTAL);
    localparam int Y_BITS    = $clog2(`V_TOTAL_INTERLACED);
    localparam int AW        = `RAM_ADDR_BITS;
    localparam int VSYNC_END = `V_SYNC_START + `V_SYNC_WIDTH;

    logic              line_doubler_q;
    logic              add_line_q;
    logic              mode_change;
    logic              restart;
    logic              running;
    logic [X_BITS-1:0] counter_x;
    logic [X_BITS-1:0] counter_x_q;
    logic [X_BITS-1:0] counter_x_q_q;
    logic [Y_BITS-1:0] counter_y;
    logic [Y_BITS-1:0] counter_y_q;
    logic [Y_BITS-1:0] counter_y_q_q;
    logic              valid_q;
    logic              valid_q_q;
    logic              hsync_q;
    logic              vsync_q;
    logic              field_q;
    logic [Y_BITS-1:0] frame_lines;
    logic [Y_BITS-1:0] vsync_end_line;
    logic [AW-1:0]     buf_col;
    logic [AW-1:0]     buf_line;

    // picture area that comes from the line buffer
    function automatic logic in_window(input logic [X_BITS-1:0] x, input logic [Y_BITS-1:0] y);
        return x >= `H_OFFSET && x < `H_VISIBLE - `H_OFFSET
            && y >= `V_OFFSET && y < `V_VISIBLE - `V_OFFSET;
    endfunction

    function automatic logic in_visible(input logic [X_BITS-1:0] x, input logic [Y_BITS-1:0] y);
        return x < `H_VISIBLE && y < `V_VISIBLE;
    endfunction

    assign mode_change = (line_doubler != line_doubler_q) || (add_line != add_line_q);
    assign restart     = !reset || mode_change;
    assign frame_lines = add_line_q ? Y_BITS'(`V_TOTAL_INTERLACED) : Y_BITS'(`V_TOTAL);
    // vsync may end in the first lines of the next frame
    assign vsync_end_line = (VSYNC_END >= frame_lines) ? Y_BITS'(VSYNC_END) - frame_lines
                                                       : Y_BITS'(VSYNC_END);

    always_ff @(posedge clock) begin
        if (!reset) begin
            line_doubler_q <= 1'b0;
            add_line_q     <= 1'b0;
        end else begin
            line_doubler_q <= line_doubler;
            add_line_q     <= add_line;
        end
    end

    always_ff @(posedge clock) begin
        if (restart) begin
            running       <= 1'b0;
            counter_x     <= '0;
            counter_y     <= '0;
            counter_x_q   <= '0;
            counter_y_q   <= '0;
            counter_x_q_q <= '0;
            counter_y_q_q <= '0;
            valid_q       <= 1'b0;
            valid_q_q     <= 1'b0;
            hsync_q       <= ~`HSYNC_ACTIVE;
            vsync_q       <= ~`VSYNC_ACTIVE;
            field_q       <= 1'b0;
        end else if (!running) begin
            running <= start_trigger;  // frozen until the capture side has a frame
        end else begin
            if (counter_x == X_BITS'(`H_TOTAL - 1)) begin
                counter_x <= '0;
                if (counter_y == frame_lines - 1'b1) begin
                    counter_y <= '0;
                    field_q   <= (line_doubler_q && !add_line_q) ? ~field_q : 1'b0;
                end else begin
                    counter_y <= counter_y + 1'b1;
                end
            end else begin
                counter_x <= counter_x + 1'b1;
            end

            counter_x_q   <= counter_x;
            counter_y_q   <= counter_y;
            counter_x_q_q <= counter_x_q;
            counter_y_q_q <= counter_y_q;
            valid_q       <= 1'b1;
            valid_q_q     <= valid_q;

            if (counter_x_q >= `H_SYNC_START && counter_x_q < `H_SYNC_START + `H_SYNC_WIDTH) begin
                hsync_q <= `HSYNC_ACTIVE;
            end else begin
                hsync_q <= ~`HSYNC_ACTIVE;
            end

            // both vsync edges on an hsync leading edge
            if (counter_x_q == X_BITS'(`H_SYNC_START)) begin
                if (counter_y_q == Y_BITS'(`V_SYNC_START)) begin
                    vsync_q <= `VSYNC_ACTIVE;
                end else if (counter_y_q == vsync_end_line) begin
                    vsync_q <= ~`VSYNC_ACTIVE;
                end
            end
        end
    end

    assign buf_col  = AW'(counter_x / `PIXEL_FACTOR - `H_OFFSET / `PIXEL_FACTOR);
    assign buf_line = AW'((counter_y / `PIXEL_FACTOR - `V_OFFSET / `PIXEL_FACTOR) % `BUF_LINES);
    assign rd_addr  = in_window(counter_x, counter_y) ? AW'(buf_line * `BUF_LINE_LEN + buf_col)
                                                      : '0;

    // rd_data belongs to the position two stages back
    assign rgb = in_window(counter_x_q_q, counter_y_q_q) ? rd_data : '0;

    assign sync.hsync     = hsync_q;
    assign sync.vsync     = vsync_q;
    assign sync.field     = field_q;
    assign sync.draw_area = valid_q_q && in_visible(counter_x_q_q, counter_y_q_q);

endmodule

//--- logic/scan_converter_top.sv
`timescale 1ns/1ps
`include "video_cfg.svh"

module scan_converter_top (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   in_valid,
    input  video_pkg::pixel_beat_t in_beat,
    output logic                   credit_return,
    input  logic                   line_doubler,
    input  logic                   add_line,
    output video_pkg::rgb_t        rgb,
    output video_pkg::sync_out_t   sync
);
    import video_pkg::*;

    pixel_beat_t               queue_beat;
    logic                      queue_not_empty;
    logic                      queue_pop;
    logic                      ram_wr_en;
    logic [`RAM_ADDR_BITS-1:0] ram_wr_addr;
    rgb_t                      ram_wr_data;
    logic [`RAM_ADDR_BITS-1:0] ram_rd_addr;
    rgb_t                      ram_rd_data;
    logic                      start_trigger;

    pixel_queue u_queue (
        .clock         (clock),
        .reset         (reset),
        .in_valid      (in_valid),
        .in_beat       (in_beat),
        .pop           (queue_pop),
        .out_beat      (queue_beat),
        .not_empty     (queue_not_empty),
        .credit_return (credit_return)
    );

    pixel_capture u_capture (
        .clock         (clock),
        .reset         (reset),
        .beat          (queue_beat),
        .not_empty     (queue_not_empty),
        .pop           (queue_pop),
        .wr_en         (ram_wr_en),
        .wr_addr       (ram_wr_addr),
        .wr_data       (ram_wr_data),
        .start_trigger (start_trigger)
    );

    line_ram u_ram (
        .clock   (clock),
        .wr_en   (ram_wr_en),
        .wr_addr (ram_wr_addr),
        .wr_data (ram_wr_data),
        .rd_addr (ram_rd_addr),
        .rd_data (ram_rd_data)
    );

    video_timing u_timing (
        .clock         (clock),
        .reset         (reset),
        .start_trigger (start_trigger),
        .line_doubler  (line_doubler),
        .add_line      (add_line),
        .rd_addr       (ram_rd_addr),
        .rd_data       (ram_rd_data),
        .rgb           (rgb),
        .sync          (sync)
    );

endmodule

//--- dv/scan_converter_assert.sv
`timescale 1ns/1ps
`include "video_cfg.svh"

module scan_converter_assert (
    input logic                                   clock,
    input logic                                   reset,
    input logic                                   in_valid,
    input video_pkg::pixel_beat_t                 in_beat,
    input logic                                   credit_return,
    input logic                                   start_trigger,
    input logic                                   line_doubler,
    input logic                                   add_line,
    input video_pkg::rgb_t                        rgb,
    input video_pkg::sync_out_t                   sync,
    input logic [$clog2(`QUEUE_DEPTH + 1)-1:0]    queue_count
);
    import video_pkg::*;

    int   fail_count = 0;
    int   credits;
    int   sent;
    int   returned;
    int   sofs;
    int   hs_gap;
    int   vs_gap;
    int   ox;
    int   oy;
    int   frame_lines;
    logic ld_q;
    logic al_q;
    logic frozen;
    logic ever_started;
    logic hs_d;
    logic vs_d;
    logic hs_seen;
    logic vs_seen;
    logic pos_valid;
    logic field_at_vs;
    logic in_win;
    logic [7:0] col;
    logic [7:0] row;
    rgb_t exp_rgb;

    wire hs      = (sync.hsync == `HSYNC_ACTIVE);
    wire vs      = (sync.vsync == `VSYNC_ACTIVE);
    wire hs_rise = hs && !hs_d;
    wire vs_rise = vs && !vs_d;

    assign frame_lines = al_q ? `V_TOTAL_INTERLACED : `V_TOTAL;
    assign in_win = ox >= `H_OFFSET && ox < `H_VISIBLE - `H_OFFSET
                 && oy >= `V_OFFSET && oy < `V_VISIBLE - `V_OFFSET;
    assign col = 8'(ox / `PIXEL_FACTOR - `H_OFFSET / `PIXEL_FACTOR);
    assign row = 8'((oy / `PIXEL_FACTOR - `V_OFFSET / `PIXEL_FACTOR) % `BUF_LINES);
    assign exp_rgb = in_win ? {col, row, 8'h5a} : '0;  // source color rule

    always_ff @(posedge clock) begin
        if (!reset) begin
            credits  <= `QUEUE_DEPTH;
            sent     <= 0;
            returned <= 0;
            sofs     <= 0;
            ld_q     <= 1'b0;
            al_q     <= 1'b0;
        end else begin
            credits  <= credits - int'(in_valid) + int'(credit_return);
            sent     <= sent + int'(in_valid);
            returned <= returned + int'(credit_return);
            sofs     <= sofs + int'(in_valid && in_beat.start_of_frame);
            ld_q     <= line_doubler;
            al_q     <= add_line;
        end
    end

    // raster is held from reset or a mode change until a start trigger
    always_ff @(posedge clock) begin
        if (!reset || line_doubler != ld_q || add_line != al_q) begin
            frozen <= 1'b1;
        end else if (start_trigger) begin
            frozen <= 1'b0;
        end
        ever_started <= reset && (ever_started || start_trigger);
    end

    always_ff @(posedge clock) begin
        hs_d   <= hs;
        vs_d   <= vs;
        hs_gap <= hs_rise ? 1 : hs_gap + 1;  // clocks since the last leading edge
        vs_gap <= vs_rise ? 1 : vs_gap + 1;
        if (vs_rise) begin
            field_at_vs <= sync.field;
        end
        if (frozen) begin
            hs_seen   <= 1'b0;
            vs_seen   <= 1'b0;
            pos_valid <= 1'b0;
        end else begin
            hs_seen <= hs_seen || hs_rise;
            vs_seen <= vs_seen || vs_rise;
            if (vs_rise && sofs >= 2) begin
                pos_valid <= 1'b1;
                ox        <= `H_SYNC_START + 1;
                oy        <= `V_SYNC_START;
            end else if (ox == `H_TOTAL - 1) begin
                ox <= 0;
                oy <= (oy == frame_lines - 1) ? 0 : oy + 1;
            end else begin
                ox <= ox + 1;
            end
        end
    end

    a_idle: assert property (@(posedge clock) disable iff (!reset)
        frozen |-> !hs && !vs && rgb == '0 && !sync.draw_area && !sync.field
                   && (ever_started || start_trigger || !credit_return))
    else begin
        fail_count++;
        $error("outputs moved while the raster was held");
    end

    // a returned credit may be spent in the cycle it shows up
    a_credit: assert property (@(posedge clock) disable iff (!reset)
        (!in_valid || credits + int'(credit_return) > 0) && returned <= sent
        && queue_count <= `QUEUE_DEPTH)
    else begin
        fail_count++;
        $error("credit rule broken or queue overfilled");
    end

    a_hsync: assert property (@(posedge clock) disable iff (!reset)
        !frozen && hs_seen && (hs_rise || (hs_d && !hs))
        |-> hs_gap == (hs_rise ? `H_TOTAL : `H_SYNC_WIDTH))
    else begin
        fail_count++;
        $error("ERROR hsync: expected %0d actual %0d",
               $sampled(hs_rise) ? `H_TOTAL : `H_SYNC_WIDTH, $sampled(hs_gap));
    end

    a_vsync_edge: assert property (@(posedge clock) disable iff (!reset)
        vs_rise |-> hs_rise && (!vs_seen || vs_gap == frame_lines * `H_TOTAL))
    else begin
        fail_count++;
        $error("ERROR vsync period: expected %0d actual %0d",
               $sampled(frame_lines) * `H_TOTAL, $sampled(vs_gap));
    end

    a_vsync_len: assert property (@(posedge clock) disable iff (!reset)
        !frozen && vs_seen && vs_d && !vs |-> vs_gap == `V_SYNC_WIDTH * `H_TOTAL)
    else begin
        fail_count++;
        $error("ERROR vsync width: expected %0d actual %0d",
               `V_SYNC_WIDTH * `H_TOTAL, $sampled(vs_gap));
    end

    a_field: assert property (@(posedge clock) disable iff (!reset)
        (ld_q && !al_q) ? (!(vs_seen && vs_rise) || sync.field != field_at_vs) : !sync.field)
    else begin
        fail_count++;
        $error("field did not follow the line doubler mode");
    end

    a_pixel: assert property (@(posedge clock) disable iff (!reset)
        !frozen && pos_valid
        |-> rgb == exp_rgb && sync.draw_area == (ox < `H_VISIBLE && oy < `V_VISIBLE))
    else begin
        fail_count++;
        $error("ERROR pixel: expected %h actual %h", $sampled(exp_rgb), $sampled(rgb));
    end

endmodule

//--- dv/tb_scan_converter.sv
`timescale 1ns/1ps
`include "video_cfg.svh"

module tb_scan_converter;
    import video_pkg::*;

    logic        clock = 1'b0;
    logic        reset;
    logic        in_valid;
    logic        credit_return;
    logic        line_doubler;
    logic        add_line;
    pixel_beat_t in_beat;
    rgb_t        rgb;
    sync_out_t   sync;
    int          seed;
    int          credits;
    int          stall_cycles;
    int          pix;

    scan_converter_top dut (.*);

    bind scan_converter_top scan_converter_assert checks (.*, .queue_count(u_queue.count));

    always #10 clock = ~clock;

    // first assertion failure ends the run
    always @(negedge clock) begin
        if (dut.checks.fail_count != 0) begin
            $display("TEST RESULT: FAIL");
            $fatal(1, "a bound assertion failed");
        end
    end

    task automatic drive_source();
        forever begin
            @(negedge clock);
            if (credit_return) begin
                credits++;
            end
            in_valid = 1'b0;
            if (credits == 0) begin
                stall_cycles++;  // wants to send but holds no credit
            end else if ($random(seed) % 8 != 0) begin
                in_beat.pixel          = {8'(pix % `BUF_LINE_LEN), 8'(pix / `BUF_LINE_LEN), 8'h5a};
                in_beat.start_of_frame = (pix == 0);
                in_valid               = 1'b1;
                credits--;
                pix = (pix + 1) % (`BUF_LINE_LEN * `BUF_LINES);
            end
        end
    endtask

    task automatic wait_sync_edges(input bit use_vsync, input int count, input string what,
                                   input int limit);
        int   cycles;
        int   seen;
        logic level;
        logic was;
        cycles = 0;
        seen   = 0;
        was    = use_vsync ? (sync.vsync == `VSYNC_ACTIVE) : (sync.hsync == `HSYNC_ACTIVE);
        while (seen < count) begin
            @(negedge clock);
            cycles++;
            level = use_vsync ? (sync.vsync == `VSYNC_ACTIVE) : (sync.hsync == `HSYNC_ACTIVE);
            if (level && !was) begin
                seen++;
            end
            was = level;
            if (cycles > limit) begin
                $display("TEST RESULT: FAIL");
                $fatal(1, "timed out waiting for %s", what);
            end
        end
    endtask

    initial begin
        seed         = 32'hae7c0ccc;
        credits      = `QUEUE_DEPTH;
        stall_cycles = 0;
        pix          = 0;
        reset        = 1'b0;
        in_valid     = 1'b0;
        in_beat      = '0;
        line_doubler = 1'b0;
        add_line     = 1'b0;
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
        fork
            drive_source();
        join_none
        wait_sync_edges(1'b0, 1, "the first hsync", 200);
        wait_sync_edges(1'b1, 3, "vsync in normal mode", 1200);
        add_line = 1'b1;  // restarts the raster
        wait_sync_edges(1'b1, 3, "vsync in add-line mode", 1300);
        line_doubler = 1'b1;
        add_line     = 1'b0;
        wait_sync_edges(1'b1, 4, "vsync in line doubler mode", 1600);
        if (stall_cycles == 0 || dut.checks.fail_count != 0) begin
            $display("TEST RESULT: FAIL");
            $fatal(1, "the source never waited for a credit or an assertion failed");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

//--- files.f
+incdir+logic
logic/video_pkg.sv
logic/pixel_queue.sv
logic/pixel_capture.sv
logic/line_ram.sv
logic/video_timing.sv
logic/scan_converter_top.sv
dv/scan_converter_assert.sv
dv/tb_scan_converter.sv

//--- run.sh
#!/bin/sh
# build and run, the exit status carries the result
verilator --binary --assert -Wno-fatal --top-module tb_scan_converter -f files.f -o sim_tb \
    && ./obj_dir/sim_tb +verilator+error+limit+100 \
    || exit 1
